// ==== logic/trace_defs.svh ====
// Trace encoder parameters

`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// Instruction address width
`define TRACE_XLEN 32

// Exception cause and privilege field widths
`define TRACE_CAUSELEN 5
`define TRACE_PRIVLEN 2

// Widest packet, branch-full with a 31 bit map and an address
`define TRACE_PACKET_LEN 72

// Width of the packet length field in bits
`define TRACE_LEN_W 7

// Packet queue entries
`define TRACE_FIFO_DEPTH 4

// Branch outcomes held before the map must be flushed
`define TRACE_MAP_MAX 31

`endif

// ==== logic/trace_pkg.sv ====
// Trace encoder types

`default_nettype none

`include "trace_defs.svh"

package trace_pkg;

    // Field vectors
    typedef logic [`TRACE_XLEN-1:0]     addr_t;
    typedef logic [`TRACE_CAUSELEN-1:0] cause_t;
    typedef logic [`TRACE_PRIVLEN-1:0]  priv_t;

    // Branch map and the number of valid outcomes in it
    typedef logic [`TRACE_MAP_MAX-1:0]          branch_map_t;
    typedef logic [$clog2(`TRACE_MAP_MAX+1)-1:0] map_cnt_t;

    // Packet payload and its length in bits
    typedef logic [`TRACE_PACKET_LEN-1:0] packet_bits_t;
    typedef logic [`TRACE_LEN_W-1:0]      packet_len_t;

    // Packet format, sent in the two lowest bits
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'h0,
        F_BRANCH_DIFF = 2'h1,
        F_ADDR_ONLY   = 2'h2,
        F_SYNC        = 2'h3
    } format_t;

    // Subformat of a sync packet
    typedef enum logic [1:0] {
        SF_START     = 2'h0,
        SF_EXCEPTION = 2'h1,
        SF_CONTEXT   = 2'h2,
        SF_UNDEF     = 2'h3
    } subformat_t;

    // Serializer FSM
    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } ser_state_t;

endpackage

`default_nettype wire

// ==== logic/packet_if.sv ====
// Packet transfer interface

`timescale 1ns/1ps
`default_nettype none

interface packet_if
    import trace_pkg::*;
();

    // Payload, valid from bit 0 up to len-1
    packet_bits_t bits;
    packet_len_t  len;

    // Transfer happens in each cycle with valid and grant both high
    logic         valid;
    logic         grant;

    modport source (
        output bits,
        output len,
        output valid,
        input  grant
    );

    modport sink (
        input  bits,
        input  len,
        input  valid,
        output grant
    );

endinterface

`default_nettype wire

// ==== logic/branch_map_tracker.sv ====
// Branch map tracker

`timescale 1ns/1ps
`default_nettype none

`include "trace_defs.svh"

module branch_map_tracker
    import trace_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  retire_valid_i,
    input  wire logic  is_branch_i,
    input  wire logic  branch_taken_i,
    input  wire logic  flush_i,
    output branch_map_t map_o,
    output map_cnt_t    map_cnt_o,
    output logic        map_full_o
);

    localparam map_cnt_t MAP_MAX = map_cnt_t'(`TRACE_MAP_MAX);

    branch_map_t map_q, map_d;
    map_cnt_t    cnt_q, cnt_d;
    logic        append;

    assign append = retire_valid_i && is_branch_i;

    // Flush first, so a branch in the same cycle lands at position 0
    always_comb begin
        map_d = map_q;
        cnt_d = cnt_q;
        if (flush_i) begin
            map_d = '0;
            cnt_d = '0;
        end
        // Saturates at capacity, further outcomes are lost
        if (append && (cnt_d != MAP_MAX)) begin
            map_d[cnt_d] = branch_taken_i;
            cnt_d        = cnt_d + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q <= '0;
            cnt_q <= '0;
        end else begin
            map_q <= map_d;
            cnt_q <= cnt_d;
        end
    end

    assign map_o      = map_q;
    assign map_cnt_o  = cnt_q;
    assign map_full_o = (cnt_q == MAP_MAX);

    // Stored outcomes only sit below the count
    map_within_count: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (map_q >> cnt_q) == '0
    ) else $error("branch map holds outcomes at or above count %0d", cnt_q);

endmodule

`default_nettype wire

// ==== logic/packet_emitter.sv ====
// Trace packet emitter

`timescale 1ns/1ps
`default_nettype none

`include "trace_defs.svh"

module packet_emitter
    import trace_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  req_valid_i,
    input  format_t     format_i,
    input  subformat_t  subformat_i,
    input  wire logic  interrupt_i,
    input  cause_t      cause_i,
    input  priv_t       priv_i,
    input  addr_t       iaddr_i,
    input  wire logic  is_branch_i,
    input  wire logic  discontinuity_i,
    input  branch_map_t map_i,
    input  map_cnt_t    map_cnt_i,
    input  wire logic  map_full_i,
    output logic        flush_o,
    packet_if.source    pkt_o
);

    // Format and branch count in front of the map
    localparam int unsigned HDR_LEN   = 9;
    localparam int unsigned START_LEN = 2 + 2 + `TRACE_PRIVLEN + 1 + `TRACE_XLEN;
    localparam int unsigned EXC_LEN   = START_LEN + `TRACE_CAUSELEN + 1;

    packet_bits_t pkt_bits;
    packet_len_t  pkt_len;
    packet_len_t  map_width;
    branch_map_t  map_mask;
    logic [EXC_LEN-3:0] sync_body;
    logic         flush_q;

    // Smallest map bucket that covers the count
    always_comb begin
        if (map_cnt_i <= 5'd1) begin
            map_width = packet_len_t'(1);
        end else if (map_cnt_i <= 5'd9) begin
            map_width = packet_len_t'(9);
        end else if (map_cnt_i <= 5'd17) begin
            map_width = packet_len_t'(17);
        end else if (map_cnt_i <= 5'd25) begin
            map_width = packet_len_t'(25);
        end else begin
            map_width = packet_len_t'(`TRACE_MAP_MAX);
        end
    end

    assign map_mask  = ~({`TRACE_MAP_MAX{1'b1}} << map_width);

    // Sync fields from bit 2 upward, the start packet uses the lower part
    assign sync_body = {interrupt_i, cause_i, iaddr_i, is_branch_i, priv_i, subformat_i};

    always_comb begin
        pkt_bits      = '0;
        pkt_len       = '0;
        pkt_bits[1:0] = format_i;
        case (format_i)
            F_BRANCH_FULL: begin
                pkt_bits[6:2] = map_cnt_i;
                pkt_bits      = pkt_bits | (packet_bits_t'(map_i & map_mask) << HDR_LEN);
                // Full map drops the address unless the flow was discontinuous
                if (map_full_i && !discontinuity_i) begin
                    pkt_len = packet_len_t'(HDR_LEN + `TRACE_MAP_MAX);
                end else begin
                    pkt_bits = pkt_bits |
                               (packet_bits_t'(iaddr_i) << (packet_len_t'(HDR_LEN) + map_width));
                    pkt_len  = packet_len_t'(HDR_LEN + `TRACE_XLEN) + map_width;
                end
            end
            F_ADDR_ONLY: begin
                pkt_bits[2 +: `TRACE_XLEN] = iaddr_i;
                pkt_len                    = packet_len_t'(2 + `TRACE_XLEN);
            end
            F_SYNC: begin
                if (subformat_i == SF_EXCEPTION) begin
                    pkt_bits[2 +: EXC_LEN-2] = sync_body;
                    pkt_len                  = packet_len_t'(EXC_LEN);
                end else begin
                    pkt_bits[2 +: START_LEN-2] = sync_body[START_LEN-3:0];
                    pkt_len                    = packet_len_t'(START_LEN);
                end
            end
            default: begin
                // Branch-diff is not encoded
                pkt_len = '0;
            end
        endcase
    end

    assign pkt_o.bits  = pkt_bits;
    assign pkt_o.len   = pkt_len;
    assign pkt_o.valid = req_valid_i;

    // Tracker restarts its map one cycle after a branch-full request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= req_valid_i && (format_i == F_BRANCH_FULL);
        end
    end

    assign flush_o = flush_q;

    branch_diff_unimplemented: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> (format_i != F_BRANCH_DIFF)
    ) else $error("branch-diff packet format is not implemented");

    branch_full_map_nonempty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && (format_i == F_BRANCH_FULL) |-> (map_cnt_i != '0)
    ) else $error("branch-full packet requested with an empty branch map");

    sync_subformat_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && (format_i == F_SYNC) |-> subformat_i inside {SF_START, SF_EXCEPTION}
    ) else $error("sync subformat %0d is not supported", subformat_i);

    // Grant from the queue is its not-full flag
    packet_fifo_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> pkt_o.grant
    ) else $error("packet FIFO overflow, request dropped");

endmodule

`default_nettype wire

// ==== logic/packet_fifo.sv ====
// Packet queue

`timescale 1ns/1ps
`default_nettype none

`include "trace_defs.svh"

module packet_fifo
    import trace_pkg::*;
#(
    parameter int unsigned DEPTH = `TRACE_FIFO_DEPTH
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    packet_if.sink     wr,
    packet_if.source   rd
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    packet_bits_t bits_mem [DEPTH];
    packet_len_t  len_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign push = wr.valid && wr.grant;
    assign pop  = rd.valid && rd.grant;

    // Write side sees not-full, read side sees not-empty
    assign wr.grant = (count_q != CNT_W'(DEPTH));
    assign rd.valid = (count_q != '0);
    assign rd.bits  = bits_mem[rd_ptr_q];
    assign rd.len   = len_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            bits_mem[wr_ptr_q] <= wr.bits;
            len_mem[wr_ptr_q]  <= wr.len;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Pointers meet whenever the queue is empty, else a pop ran past the last entry
    fifo_no_underrun: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (count_q == '0) |-> (rd_ptr_q == wr_ptr_q)
    ) else $error("packet FIFO popped while empty");

endmodule

`default_nettype wire

// ==== logic/packet_serializer.sv ====
// Packet byte serializer

`timescale 1ns/1ps
`default_nettype none

`include "trace_defs.svh"

module packet_serializer
    import trace_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_ni,
    packet_if.sink     pkt_i,
    output logic [7:0] byte_o,
    output logic       byte_valid_o,
    output logic       byte_last_o
);

    ser_state_t state_q;
    packet_bits_t shift_q;

    // Length rounded up to whole bytes
    logic [`TRACE_LEN_W:0]   len_round;
    logic [`TRACE_LEN_W-3:0] num_bytes;
    logic [`TRACE_LEN_W-3:0] bytes_left_q;

    assign len_round = {1'b0, pkt_i.len} + (`TRACE_LEN_W + 1)'(7);
    assign num_bytes = len_round[`TRACE_LEN_W:3];

    // Accept only between packets
    assign pkt_i.grant = (state_q == SER_IDLE);

    always_ff @(posedge clk_i) begin
        if ((state_q == SER_IDLE) && pkt_i.valid) begin
            shift_q <= pkt_i.bits;
        end else if (state_q == SER_SEND) begin
            shift_q <= shift_q >> 8;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= SER_IDLE;
            bytes_left_q <= '0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    // A zero-length packet is consumed without output
                    if (pkt_i.valid && (num_bytes != '0)) begin
                        bytes_left_q <= num_bytes;
                        state_q      <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    bytes_left_q <= bytes_left_q - 1'b1;
                    if (bytes_left_q == 1) begin
                        state_q <= SER_IDLE;
                    end
                end
                default: state_q <= SER_IDLE;
            endcase
        end
    end

    assign byte_o       = shift_q[7:0];
    assign byte_valid_o = (state_q == SER_SEND);
    assign byte_last_o  = (state_q == SER_SEND) && (bytes_left_q == 1);

endmodule

`default_nettype wire

// ==== logic/trace_encoder_top.sv ====
// Trace encoder packet stage

`timescale 1ns/1ps
`default_nettype none

module trace_encoder_top
    import trace_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_ni,
    // Retired instruction stream
    input  wire logic retire_valid_i,
    input  wire logic is_branch_i,
    input  wire logic branch_taken_i,
    // Packet request
    input  wire logic req_valid_i,
    input  format_t    format_i,
    input  subformat_t subformat_i,
    input  wire logic interrupt_i,
    input  cause_t     cause_i,
    input  priv_t      priv_i,
    input  addr_t      iaddr_i,
    input  wire logic discontinuity_i,
    // Byte stream
    output logic [7:0] byte_o,
    output logic       byte_valid_o,
    output logic       byte_last_o
);

    branch_map_t map;
    map_cnt_t    map_cnt;
    logic        map_full;
    logic        map_flush;

    // Emitter to queue, queue to serializer
    packet_if emit_if ();
    packet_if ser_if ();

    branch_map_tracker u_tracker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .retire_valid_i (retire_valid_i),
        .is_branch_i    (is_branch_i),
        .branch_taken_i (branch_taken_i),
        .flush_i        (map_flush),
        .map_o          (map),
        .map_cnt_o      (map_cnt),
        .map_full_o     (map_full)
    );

    packet_emitter u_emitter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .format_i        (format_i),
        .subformat_i     (subformat_i),
        .interrupt_i     (interrupt_i),
        .cause_i         (cause_i),
        .priv_i          (priv_i),
        .iaddr_i         (iaddr_i),
        .is_branch_i     (is_branch_i),
        .discontinuity_i (discontinuity_i),
        .map_i           (map),
        .map_cnt_i       (map_cnt),
        .map_full_i      (map_full),
        .flush_o         (map_flush),
        .pkt_o           (emit_if.source)
    );

    packet_fifo u_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .wr     (emit_if.sink),
        .rd     (ser_if.source)
    );

    packet_serializer u_serializer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pkt_i        (ser_if.sink),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o),
        .byte_last_o  (byte_last_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_trace_encoder.sv ====
// Trace encoder testbench

`timescale 1ns/1ps
`default_nettype none

`include "trace_defs.svh"

module tb_trace_encoder
    import trace_pkg::*;
();

    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;
    localparam int MAP_MAX         = `TRACE_MAP_MAX;

    logic        clk;
    logic        rst_n;

    // DUT inputs
    logic        retire_valid;
    logic        is_branch;
    logic        branch_taken;
    logic        req_valid;
    format_t     format_sel;
    subformat_t  subformat_sel;
    logic        interrupt;
    cause_t      cause;
    priv_t       priv;
    addr_t       iaddr;
    logic        discontinuity;

    // DUT outputs
    logic [7:0]  byte_out;
    logic        byte_valid;
    logic        byte_last;

    // Reference branch map and expected packets
    branch_map_t  ref_map;
    int           ref_cnt;
    packet_bits_t exp_bits_q [$];
    packet_len_t  exp_len_q [$];

    // Reassembly of the byte stream
    packet_bits_t rx_acc;
    int           rx_cnt;
    logic         done_q;
    logic         exp_present_q;
    packet_bits_t got_bits_q;
    packet_bits_t exp_bits_r;
    int           got_n_q;
    int           exp_n_r;

    logic         req_seen;
    int           err_count;
    int           err_mark;
    int           tests_run;
    int           tests_failed;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    trace_encoder_top u_dut (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .retire_valid_i  (retire_valid),
        .is_branch_i     (is_branch),
        .branch_taken_i  (branch_taken),
        .req_valid_i     (req_valid),
        .format_i        (format_sel),
        .subformat_i     (subformat_sel),
        .interrupt_i     (interrupt),
        .cause_i         (cause),
        .priv_i          (priv),
        .iaddr_i         (iaddr),
        .discontinuity_i (discontinuity),
        .byte_o          (byte_out),
        .byte_valid_o    (byte_valid),
        .byte_last_o     (byte_last)
    );

    // Bytes are collected mid-cycle, results checked on the next rising edge
    always @(negedge clk) begin : reassemble
        packet_bits_t acc;
        done_q <= 1'b0;
        if (byte_valid) begin
            acc = rx_acc | (packet_bits_t'(byte_out) << (8 * rx_cnt));
            if (byte_last) begin
                done_q     <= 1'b1;
                got_bits_q <= acc;
                got_n_q    <= rx_cnt + 1;
                if (exp_bits_q.size() != 0) begin
                    exp_present_q <= 1'b1;
                    exp_bits_r    <= exp_bits_q.pop_front();
                    exp_n_r       <= (int'(exp_len_q.pop_front()) + 7) / 8;
                end else begin
                    exp_present_q <= 1'b0;
                end
                rx_acc = '0;
                rx_cnt = 0;
            end else begin
                rx_acc = acc;
                rx_cnt = rx_cnt + 1;
            end
        end
    end

    quiet_valid: assert property (
        @(posedge clk) disable iff (!rst_n) !req_seen |-> !byte_valid
    ) else begin
        err_count++;
        $display("ERROR byte_valid_o got 0x%h expected 0x0", byte_valid);
    end

    quiet_last: assert property (
        @(posedge clk) disable iff (!rst_n) !req_seen |-> !byte_last
    ) else begin
        err_count++;
        $display("ERROR byte_last_o got 0x%h expected 0x0", byte_last);
    end

    packet_requested: assert property (
        @(posedge clk) disable iff (!rst_n) done_q |-> exp_present_q
    ) else begin
        err_count++;
        $display("A packet came out of the byte stream without a matching request");
    end

    packet_bits_match: assert property (
        @(posedge clk) disable iff (!rst_n) done_q && exp_present_q |-> got_bits_q == exp_bits_r
    ) else begin
        err_count++;
        $display("ERROR byte_o packet got 0x%h expected 0x%h", got_bits_q, exp_bits_r);
    end

    packet_bytes_match: assert property (
        @(posedge clk) disable iff (!rst_n) done_q && exp_present_q |-> got_n_q == exp_n_r
    ) else begin
        err_count++;
        $display("ERROR byte_last_o byte count got 0x%h expected 0x%h", got_n_q, exp_n_r);
    end

    // Narrowest map width that holds the branch count
    function automatic int map_bucket(input int cnt);
        if (cnt <= 1) return 1;
        if (cnt <= 9) return 9;
        if (cnt <= 17) return 17;
        if (cnt <= 25) return 25;
        return MAP_MAX;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        req_valid    <= 1'b0;
        retire_valid <= 1'b0;
    endtask

    task automatic retire_branches(input int n);
        logic taken;
        for (int i = 0; i < n; i++) begin
            taken = ($urandom % 2) != 0;
            @(posedge clk);
            req_valid    <= 1'b0;
            retire_valid <= 1'b1;
            is_branch    <= 1'b1;
            branch_taken <= taken;
            // Outcomes past capacity are lost
            if (ref_cnt < MAP_MAX) begin
                ref_map[ref_cnt] = taken;
                ref_cnt          = ref_cnt + 1;
            end
        end
    endtask

    // Builds the expected packet, then drives the request for one cycle
    task automatic request(input format_t fmt, input subformat_t sub, input logic disc);
        addr_t        addr;
        cause_t       cs;
        priv_t        pv;
        logic         intr;
        logic         br;
        packet_bits_t bits;
        int           len;
        int           w;
        addr = addr_t'($urandom);
        cs   = cause_t'($urandom);
        pv   = priv_t'($urandom);
        intr = ($urandom % 2) != 0;
        br   = ($urandom % 2) != 0;
        bits = packet_bits_t'(fmt);
        case (fmt)
            F_BRANCH_FULL: begin
                w    = map_bucket(ref_cnt);
                bits = bits | (packet_bits_t'(ref_cnt) << 2);
                bits = bits | ((packet_bits_t'(ref_map) & ((packet_bits_t'(1) << w) - 1)) << 9);
                if ((ref_cnt == MAP_MAX) && !disc) begin
                    len = 9 + MAP_MAX;
                end else begin
                    bits = bits | (packet_bits_t'(addr) << (9 + w));
                    len  = 9 + w + 32;
                end
            end
            F_ADDR_ONLY: begin
                bits = bits | (packet_bits_t'(addr) << 2);
                len  = 34;
            end
            default: begin
                bits = bits | (packet_bits_t'(sub) << 2) | (packet_bits_t'(pv) << 4);
                bits = bits | (packet_bits_t'(br) << 6) | (packet_bits_t'(addr) << 7);
                len  = 39;
                if (sub == SF_EXCEPTION) begin
                    bits = bits | (packet_bits_t'(cs) << 39) | (packet_bits_t'(intr) << 44);
                    len  = 45;
                end
            end
        endcase
        exp_bits_q.push_back(bits);
        exp_len_q.push_back(packet_len_t'(len));
        // Map restarts after every branch-full packet
        if (fmt == F_BRANCH_FULL) begin
            ref_map = '0;
            ref_cnt = 0;
        end
        @(posedge clk);
        req_valid     <= 1'b1;
        retire_valid  <= 1'b0;
        format_sel    <= fmt;
        subformat_sel <= sub;
        interrupt     <= intr;
        cause         <= cs;
        priv          <= pv;
        iaddr         <= addr;
        is_branch     <= br;
        discontinuity <= disc;
        req_seen      <= 1'b1;
    endtask

    // Waits until every expected packet has come out
    task automatic drain();
        idle_cycle();
        do @(posedge clk); while (exp_bits_q.size() != 0);
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        int errs;
        drain();
        errs = err_count - err_mark;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0s (%0d errors)", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
        err_mark = err_count;
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, packets still missing", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int bf_counts [5];
        void'($urandom(49110));
        bf_counts     = '{1, 5, 12, 20, 28};
        retire_valid  = 1'b0;
        is_branch     = 1'b0;
        branch_taken  = 1'b0;
        req_valid     = 1'b0;
        format_sel    = F_ADDR_ONLY;
        subformat_sel = SF_START;
        interrupt     = 1'b0;
        cause         = '0;
        priv          = '0;
        iaddr         = '0;
        discontinuity = 1'b0;
        ref_map       = '0;
        ref_cnt       = 0;
        rx_acc        = '0;
        rx_cnt        = 0;
        done_q        = 1'b0;
        exp_present_q = 1'b0;
        req_seen      = 1'b0;
        err_count     = 0;
        err_mark      = 0;
        tests_run     = 0;
        tests_failed  = 0;

        while (!rst_n) @(posedge clk);

        repeat (8) idle_cycle();
        finish_test("quiet after reset");

        for (int i = 0; i < 2; i++) begin
            request(F_ADDR_ONLY, SF_START, 1'b0);
            drain();
            request(F_SYNC, SF_START, 1'b0);
            drain();
            request(F_SYNC, SF_EXCEPTION, 1'b0);
            drain();
        end
        finish_test("address-only and sync layouts");

        foreach (bf_counts[i]) begin
            retire_branches(bf_counts[i]);
            request(F_BRANCH_FULL, SF_START, ($urandom % 2) != 0);
            drain();
        end
        // Short map right after a flush
        retire_branches(3);
        request(F_BRANCH_FULL, SF_START, 1'b0);
        finish_test("branch map widths");

        retire_branches(31);
        request(F_BRANCH_FULL, SF_START, 1'b0);
        drain();
        retire_branches(33);
        request(F_BRANCH_FULL, SF_START, 1'b1);
        finish_test("full branch map");

        // Four requests queue up behind a long packet
        request(F_SYNC, SF_EXCEPTION, 1'b0);
        idle_cycle();
        do @(negedge clk); while (!byte_valid);
        request(F_ADDR_ONLY, SF_START, 1'b0);
        request(F_SYNC, SF_START, 1'b0);
        request(F_SYNC, SF_EXCEPTION, 1'b0);
        request(F_ADDR_ONLY, SF_START, 1'b0);
        finish_test("back-to-back burst");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if ((err_count == 0) && (tests_failed == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/trace_pkg.sv
logic/packet_if.sv
logic/branch_map_tracker.sv
logic/packet_emitter.sv
logic/packet_fifo.sv
logic/packet_serializer.sv
logic/trace_encoder_top.sv
sim/tb_clock_gen.sv
sim/tb_trace_encoder.sv
